// File: Makefile
VERILATOR = verilator
TOP       = cpu_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
rtl/cpu_pkg.sv
rtl/apb_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/apb_master.sv
rtl/core_sequencer.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// File: rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::decoded_t        dec_i,
    input  wire [cpu_pkg::XLEN-1:0]       rs1_data_i,
    input  wire [cpu_pkg::XLEN-1:0]       rs2_data_i,
    input  wire [cpu_pkg::XLEN-1:0]       pc_i,
    output logic [cpu_pkg::XLEN-1:0]      result_o,
    output logic [cpu_pkg::XLEN-1:0]      mem_addr_o,
    output logic                          branch_taken_o,
    output logic [cpu_pkg::XLEN-1:0]      jump_target_o
);

    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] addr_sum; // rs1 + imm, shared by lw/sw and jalr
    logic                     cond;

    assign op_b     = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign addr_sum = rs1_data_i + dec_i.imm;

    always_comb begin
        case (dec_i.alu_op)
            cpu_pkg::ADD:    result_o = rs1_data_i + op_b;
            cpu_pkg::SUB:    result_o = rs1_data_i - op_b;
            cpu_pkg::XOR:    result_o = rs1_data_i ^ op_b;
            cpu_pkg::OR:     result_o = rs1_data_i | op_b;
            cpu_pkg::AND:    result_o = rs1_data_i & op_b;
            cpu_pkg::SLL:    result_o = rs1_data_i << op_b[4:0];
            cpu_pkg::SRL:    result_o = rs1_data_i >> op_b[4:0];
            cpu_pkg::PASS_B: result_o = op_b;
            default:         result_o = '0;
        endcase
    end

    // branch conditions, signed compare
    always_comb begin
        case (dec_i.funct3)
            3'b000:  cond = (rs1_data_i == rs2_data_i);
            3'b001:  cond = (rs1_data_i != rs2_data_i);
            3'b100:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            3'b101:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken_o = dec_i.is_branch & cond;
    assign mem_addr_o     = addr_sum;

    // jalr clears bit 0, branch and jal are pc relative
    assign jump_target_o = dec_i.is_jalr ? {addr_sum[cpu_pkg::XLEN-1:1], 1'b0}
                                         : pc_i + dec_i.imm;

endmodule

`default_nettype wire

// File: rtl/apb_master.sv
`timescale 1ns/10ps
`default_nettype none

module apb_master (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start_i,
    input  wire [31:0]          addr_i,
    input  wire                 write_i,
    input  wire [31:0]          wdata_i,
    output logic                done_o,
    output logic [31:0]         rdata_o,
    output apb_pkg::apb_req_t   apb_req_o,
    input  wire apb_pkg::apb_rsp_t apb_rsp_i
);

    // psel/penable double as the state: idle 00, setup 10, access 11
    logic        psel_q;
    logic        penable_q;
    logic        pwrite_q;
    logic [31:0] paddr_q;
    logic [31:0] pwdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end else if (!psel_q) begin
            psel_q <= start_i;
        end else if (!penable_q) begin
            penable_q <= 1'b1; // setup always lasts one cycle
        end else if (apb_rsp_i.pready) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end
    end

    // request captured once, held through wait states
    always_ff @(posedge clk) begin
        if (!psel_q && start_i) begin
            paddr_q  <= addr_i;
            pwrite_q <= write_i;
            pwdata_q <= wdata_i;
        end
    end

    assign done_o  = psel_q & penable_q & apb_rsp_i.pready;
    assign rdata_o = apb_rsp_i.prdata;

    always_comb begin
        apb_req_o.paddr   = paddr_q;
        apb_req_o.pwdata  = pwdata_q;
        apb_req_o.psel    = psel_q;
        apb_req_o.penable = penable_q;
        apb_req_o.pwrite  = pwrite_q;
    end

    a_penable_psel : assert property (@(posedge clk) disable iff (rst)
        apb_req_o.penable |-> apb_req_o.psel);

    a_hold_on_wait : assert property (@(posedge clk) disable iff (rst)
        (psel_q && penable_q && !apb_rsp_i.pready)
            |=> $stable(paddr_q) && $stable(pwrite_q) && $stable(pwdata_q));

endmodule

`default_nettype wire

// File: rtl/apb_pkg.sv
`default_nettype none

package apb_pkg;

    // master to slave
    typedef struct packed {
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic        psel;
        logic        penable;
        logic        pwrite;
    } apb_req_t;

    // slave to master, pslverr not acted on by the core
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/core_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module core_sequencer #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire cpu_pkg::decoded_t    dec_i,
    input  wire [cpu_pkg::XLEN-1:0]   alu_result_i,
    input  wire [cpu_pkg::XLEN-1:0]   mem_addr_i,
    input  wire [cpu_pkg::XLEN-1:0]   rs2_data_i,
    input  wire                       branch_taken_i,
    input  wire [cpu_pkg::XLEN-1:0]   jump_target_i,
    input  wire                       bus_done_i,
    input  wire [cpu_pkg::XLEN-1:0]   bus_rdata_i,
    output logic [cpu_pkg::XLEN-1:0]  instr_o,
    output logic [cpu_pkg::XLEN-1:0]  pc_o,
    output logic                      bus_start_o,
    output logic [cpu_pkg::XLEN-1:0]  bus_addr_o,
    output logic                      bus_write_o,
    output logic [cpu_pkg::XLEN-1:0]  bus_wdata_o,
    output logic                      rd_we_o,
    output logic [4:0]                rd_addr_o,
    output logic [cpu_pkg::XLEN-1:0]  rd_data_o
);

    cpu_pkg::seq_state_e      state;
    logic                     busy;       // transfer issued, done not seen yet
    logic [cpu_pkg::XLEN-1:0] pc_q;
    logic [cpu_pkg::XLEN-1:0] instr_q;
    logic [cpu_pkg::XLEN-1:0] load_q;
    logic [cpu_pkg::XLEN-1:0] pc_plus4;
    logic                     mem_access;
    logic                     redirect;

    assign pc_plus4   = pc_q + 32'd4;
    assign mem_access = dec_i.valid & (dec_i.is_load | dec_i.is_store);
    assign redirect   = dec_i.valid & (dec_i.is_jal | dec_i.is_jalr | branch_taken_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpu_pkg::FETCH;
            busy  <= 1'b0;
            pc_q  <= RESET_VECTOR;
        end else begin
            if (bus_start_o) begin
                busy <= 1'b1;
            end else if (bus_done_i) begin
                busy <= 1'b0;
            end
            case (state)
                cpu_pkg::FETCH: begin
                    if (bus_done_i) begin
                        state <= cpu_pkg::EXECUTE;
                    end
                end
                cpu_pkg::EXECUTE: begin
                    state <= mem_access ? cpu_pkg::MEMORY : cpu_pkg::WRITEBACK;
                end
                cpu_pkg::MEMORY: begin
                    if (bus_done_i) begin
                        state <= cpu_pkg::WRITEBACK;
                    end
                end
                default: begin // writeback, rd is written on this same edge
                    state <= cpu_pkg::FETCH;
                    pc_q  <= redirect ? jump_target_i : pc_plus4;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::FETCH) && bus_done_i) begin
            instr_q <= bus_rdata_i;
        end
        if ((state == cpu_pkg::MEMORY) && bus_done_i) begin
            load_q <= bus_rdata_i;
        end
    end

    // start right away out of reset, so the first setup follows rst
    assign bus_start_o = !busy && ((state == cpu_pkg::FETCH) || (state == cpu_pkg::MEMORY));
    assign bus_addr_o  = (state == cpu_pkg::MEMORY) ? mem_addr_i : pc_q;
    assign bus_write_o = (state == cpu_pkg::MEMORY) & dec_i.is_store;
    assign bus_wdata_o = rs2_data_i;

    assign rd_we_o   = (state == cpu_pkg::WRITEBACK) & dec_i.valid & dec_i.writes_rd;
    assign rd_addr_o = dec_i.rd;

    always_comb begin
        if (dec_i.is_load) begin
            rd_data_o = load_q;
        end else if (dec_i.is_jal || dec_i.is_jalr) begin
            rd_data_o = pc_plus4; // link value
        end else begin
            rd_data_o = alu_result_i;
        end
    end

    assign instr_o = instr_q;
    assign pc_o    = pc_q;

    // start is a single-cycle pulse and the state waits for done
    a_start_state : assert property (@(posedge clk) disable iff (rst)
        bus_start_o |=> !bus_start_o && $stable(state));

    a_state_known : assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state));

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    parameter int XLEN = 32;

    // major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        PASS_B // operand b straight through, lui
    } alu_op_e;

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;       // already sign extended
        alu_op_e         alu_op;
        logic            use_imm;   // operand b from imm instead of rs2
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            writes_rd;
        logic [2:0]      funct3;    // branch condition select
        logic            valid;
    } decoded_t;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_VECTOR = '0,
    parameter int                       NUM_REGS     = 32
) (
    input  wire                       clk,
    input  wire                       rst,
    output apb_pkg::apb_req_t         apb_req_o,
    input  wire apb_pkg::apb_rsp_t    apb_rsp_i
);

    cpu_pkg::decoded_t        dec;
    logic [cpu_pkg::XLEN-1:0] instr;
    logic [cpu_pkg::XLEN-1:0] pc;
    logic [cpu_pkg::XLEN-1:0] rs1_data;
    logic [cpu_pkg::XLEN-1:0] rs2_data;
    logic [cpu_pkg::XLEN-1:0] alu_result;
    logic [cpu_pkg::XLEN-1:0] mem_addr;
    logic                     branch_taken;
    logic [cpu_pkg::XLEN-1:0] jump_target;
    logic                     bus_start;
    logic [cpu_pkg::XLEN-1:0] bus_addr;
    logic                     bus_write;
    logic [cpu_pkg::XLEN-1:0] bus_wdata;
    logic                     bus_done;
    logic [cpu_pkg::XLEN-1:0] bus_rdata;
    logic                     rd_we;
    logic [4:0]               rd_addr;
    logic [cpu_pkg::XLEN-1:0] rd_data;

    core_sequencer #(
        .RESET_VECTOR(RESET_VECTOR)
    ) core_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .dec_i         (dec),
        .alu_result_i  (alu_result),
        .mem_addr_i    (mem_addr),
        .rs2_data_i    (rs2_data),
        .branch_taken_i(branch_taken),
        .jump_target_i (jump_target),
        .bus_done_i    (bus_done),
        .bus_rdata_i   (bus_rdata),
        .instr_o       (instr),
        .pc_o          (pc),
        .bus_start_o   (bus_start),
        .bus_addr_o    (bus_addr),
        .bus_write_o   (bus_write),
        .bus_wdata_o   (bus_wdata),
        .rd_we_o       (rd_we),
        .rd_addr_o     (rd_addr),
        .rd_data_o     (rd_data)
    );

    instr_decoder instr_decoder_i (
        .instr_i(instr),
        .dec_o  (dec)
    );

    reg_file #(
        .NUM_REGS(NUM_REGS)
    ) reg_file_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_i     (dec.rs1),
        .rs2_i     (dec.rs2),
        .rd_i      (rd_addr),
        .we_i      (rd_we),
        .wdata_i   (rd_data),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    alu alu_i (
        .dec_i         (dec),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .pc_i          (pc),
        .result_o      (alu_result),
        .mem_addr_o    (mem_addr),
        .branch_taken_o(branch_taken),
        .jump_target_o (jump_target)
    );

    apb_master apb_master_i (
        .clk      (clk),
        .rst      (rst),
        .start_i  (bus_start),
        .addr_i   (bus_addr),
        .write_i  (bus_write),
        .wdata_i  (bus_wdata),
        .done_o   (bus_done),
        .rdata_o  (bus_rdata),
        .apb_req_o(apb_req_o),
        .apb_rsp_i(apb_rsp_i)
    );

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire [cpu_pkg::XLEN-1:0] instr_i,
    output cpu_pkg::decoded_t       dec_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   f3_arith_ok; // funct3 kept for OP / OP_IMM
    logic                   op_f7_ok;
    logic                   imm_f7_ok;
    cpu_pkg::alu_op_e       arith_op;
    logic [cpu_pkg::XLEN-1:0] imm_i;
    logic [cpu_pkg::XLEN-1:0] imm_s;
    logic [cpu_pkg::XLEN-1:0] imm_b;
    logic [cpu_pkg::XLEN-1:0] imm_u;
    logic [cpu_pkg::XLEN-1:0] imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    assign f3_arith_ok = (funct3 != 3'b010) && (funct3 != 3'b011);
    // only sub carries funct7 0100000
    assign op_f7_ok = (funct7 == 7'h00) || ((funct7 == 7'h20) && (funct3 == 3'b000));
    // slli / srli need a clean funct7
    assign imm_f7_ok = (funct3[1:0] != 2'b01) || (funct7 == 7'h00);

    always_comb begin
        case (funct3)
            3'b000: begin
                if ((opcode == cpu_pkg::OP) && funct7[5]) begin
                    arith_op = cpu_pkg::SUB;
                end else begin
                    arith_op = cpu_pkg::ADD;
                end
            end
            3'b001: arith_op = cpu_pkg::SLL;
            3'b100: arith_op = cpu_pkg::XOR;
            3'b101: arith_op = cpu_pkg::SRL;
            3'b110: arith_op = cpu_pkg::OR;
            3'b111: arith_op = cpu_pkg::AND;
            default: arith_op = cpu_pkg::ADD; // also lw / sw address add
        endcase
    end

    always_comb begin
        dec_o        = '0;
        dec_o.rd     = instr_i[11:7];
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.funct3 = funct3;
        dec_o.alu_op = arith_op;
        case (opcode)
            cpu_pkg::OP: begin
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = f3_arith_ok & op_f7_ok;
            end
            cpu_pkg::OP_IMM: begin
                dec_o.imm       = imm_i;
                dec_o.use_imm   = 1'b1;
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = f3_arith_ok & imm_f7_ok;
            end
            cpu_pkg::LOAD: begin
                dec_o.imm       = imm_i;
                dec_o.use_imm   = 1'b1;
                dec_o.is_load   = 1'b1;
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = (funct3 == 3'b010); // lw only
            end
            cpu_pkg::STORE: begin
                dec_o.imm      = imm_s;
                dec_o.use_imm  = 1'b1;
                dec_o.is_store = 1'b1;
                dec_o.valid    = (funct3 == 3'b010);
            end
            cpu_pkg::BRANCH: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = 1'b1;
                dec_o.valid     = ~funct3[1]; // beq bne blt bge
            end
            cpu_pkg::JAL: begin
                dec_o.imm       = imm_j;
                dec_o.is_jal    = 1'b1;
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = 1'b1;
            end
            cpu_pkg::JALR: begin
                dec_o.imm       = imm_i;
                dec_o.use_imm   = 1'b1;
                dec_o.is_jalr   = 1'b1;
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = (funct3 == 3'b000);
            end
            cpu_pkg::LUI: begin
                dec_o.imm       = imm_u;
                dec_o.use_imm   = 1'b1;
                dec_o.alu_op    = cpu_pkg::PASS_B;
                dec_o.writes_rd = 1'b1;
                dec_o.valid     = 1'b1;
            end
            default: dec_o.valid = 1'b0; // unknown opcode, runs as a no-op
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire [$clog2(NUM_REGS)-1:0]    rs1_i,
    input  wire [$clog2(NUM_REGS)-1:0]    rs2_i,
    input  wire [$clog2(NUM_REGS)-1:0]    rd_i,
    input  wire                           we_i,
    input  wire [cpu_pkg::XLEN-1:0]       wdata_i,
    output logic [cpu_pkg::XLEN-1:0]      rs1_data_o,
    output logic [cpu_pkg::XLEN-1:0]      rs2_data_o
);

    logic [cpu_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    a_wr_idx_known : assert property (@(posedge clk) disable iff (rst)
        we_i |-> !$isunknown(rd_i));

endmodule

`default_nettype wire

// File: verification/cpu_stimulus.txt
// from @00 program words, at @c0 program length then store count,
// from @c8 one expected store per line as address then data
@00
20000093 06400113 ff900193 00310233 // x1 = 0x200, x2 = 100, x3 = -7, add
0040a023 402182b3 0050a223 12345337 // sw, sub, sw, lui x6
67834393 0070a423 0033c433 0080a623 // xori, sw, xor, sw
006164b3 0f03f513 0090a823 00a0aa23 // or, andi, sw, sw
f0016593 00b3f633 00b0ac23 00c0ae23 // ori -256, and, sw, sw
00411693 01c1d713 00300793 00f39833 00f1d8b3 // slli, srli, x15 = 3, sll, srl
02d0a023 02e0a223 0300a423 0310a623 // four stores
0080a903 00190913 0320a823          // lw, addi 1, sw
bad00993 60000a13 ffb00a93          // bad marker, good marker, x21 = -5
00210463 0330aa23 0340aa23          // beq taken
00310463 0340ac23                   // beq not taken
00311463 0330ae23 0340ae23          // bne taken
00211463 0540a023                   // bne not taken
0021c463 0530a223 0540a223          // blt -7 < 100 taken
00314463 0540a423                   // blt 100 < -7 not taken
0151c463 0530a623 0540a623          // blt -7 < -5 taken
00315463 0530a823 0540a823          // bge 100 >= -7 taken
0151d463 0540aa23                   // bge -7 >= -5 not taken
00800b6f 0530ac23 0560ac23          // jal x22, store link
10000c13 001c0be7 0530ae23 0570ae23 // jalr x23 via 0x100 + 1, store link
0000006f                            // park in a self loop
@c0
00000042 00000018
@c8
00000200 0000005d
00000204 ffffff95
00000208 12345678
0000020c edcba981
00000210 12345064
00000214 00000070
00000218 ffffff64
0000021c 12345660
00000220 00000640
00000224 0000000f
00000228 91a2b3c0
0000022c 1fffffff
00000230 12345679
00000234 00000600
00000238 00000600
0000023c 00000600
00000240 00000600
00000244 00000600
00000248 00000600
0000024c 00000600
00000250 00000600
00000254 00000600
00000258 000000ec
0000025c 000000fc

// File: verification/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

    localparam int          CLK_PERIOD       = 4;
    localparam int          RESET_CYCLES     = 4;
    localparam int          MEM_WORDS        = 256;
    localparam int          MAX_WAIT         = 3;  // two lfsr bits per delay
    localparam int          CYCLES_PER_INSTR = 40;
    localparam logic [31:0] RESET_VECTOR     = 32'h0000_0000;
    localparam logic [7:0]  META_BASE        = 8'hc0; // program length, store count
    localparam logic [7:0]  REC_BASE         = 8'hc8; // address and data pairs

    logic              clk;
    logic              rst;
    apb_pkg::apb_req_t apb_req;
    apb_pkg::apb_rsp_t apb_rsp;

    logic [31:0]       stim [MEM_WORDS];
    logic [31:0]       mem [MEM_WORDS];
    logic [15:0]       lfsr;
    int                wait_left;
    int                prog_len;
    int                store_count;
    int                stores_seen;
    apb_pkg::apb_req_t prev_req;  // bus as seen on the previous falling edge
    logic              prev_ready;
    apb_pkg::apb_req_t exp_req;

    cpu_top #(
        .RESET_VECTOR(RESET_VECTOR),
        .NUM_REGS    (32)
    ) cpu_top_i (
        .clk      (clk),
        .rst      (rst),
        .apb_req_o(apb_req),
        .apb_rsp_i(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_addr(input string name, input logic [cpu_pkg::XLEN-1:0] exp,
                              input logic [cpu_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("CHECK FAILED %s expected %08h actual %08h",
                                     name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [cpu_pkg::XLEN-1:0] exp,
                              input logic [cpu_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("CHECK FAILED %s expected %08h actual %08h",
                                     name, exp, act));
        end
    endtask

    task automatic check_apb(input string name, input apb_pkg::apb_req_t exp,
                             input apb_pkg::apb_req_t act);
        if (act !== exp) begin
            report_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                     name, exp, act));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_wait(output int cycles);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        cycles = int'(bits);
    endtask

    // compare a write against the next entry of the expected list
    task automatic record_store();
        logic [7:0] rec;
        if (stores_seen >= store_count) begin
            report_failure("a store was made beyond the end of the expected list");
        end
        rec = REC_BASE + 8'(2 * stores_seen);
        check_addr($sformatf("store %0d address", stores_seen), stim[rec], apb_req.paddr);
        check_word($sformatf("store %0d data", stores_seen), stim[rec + 8'd1],
                   apb_req.pwdata);
        stores_seen++;
    endtask

    // apb slave with random wait states, plus protocol monitor
    always @(negedge clk) begin
        if (!rst) begin
            exp_req = apb_req;
            if (prev_req.psel && !prev_req.penable) begin
                exp_req         = prev_req;
                exp_req.penable = 1'b1; // exactly one setup cycle
                check_apb("setup to access", exp_req, apb_req);
            end else if (prev_req.psel && !prev_ready) begin
                check_apb("hold during wait state", prev_req, apb_req);
            end else if (prev_req.psel) begin
                exp_req.psel    = 1'b0;
                exp_req.penable = 1'b0;
                check_apb("release after transfer", exp_req, apb_req);
            end else begin
                exp_req.penable = 1'b0; // only a setup can follow idle
                check_apb("setup before enable", exp_req, apb_req);
            end

            apb_rsp.pready = 1'b0;
            if (apb_req.psel && !apb_req.penable) begin
                draw_wait(wait_left);
            end else if (apb_req.psel && apb_req.penable) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    if (apb_req.paddr[31:10] != '0) begin
                        report_failure("the core accessed an address outside the memory");
                    end
                    apb_rsp.pready = 1'b1; // transfer ends on the next rising edge
                    if (apb_req.pwrite) begin
                        record_store();
                        mem[apb_req.paddr[9:2]] = apb_req.pwdata;
                    end else begin
                        apb_rsp.prdata = mem[apb_req.paddr[9:2]];
                    end
                end
            end
            prev_req   = apb_req;
            prev_ready = apb_rsp.pready;
        end
    end

    initial begin
        wait (prog_len > 0);
        repeat (prog_len * CYCLES_PER_INSTR * MAX_WAIT) @(posedge clk);
        report_failure("watchdog expired before all expected stores were seen");
    end

    initial begin
        rst         = 1'b1;
        apb_rsp     = '0;
        lfsr        = 16'd69;
        wait_left   = 0;
        stores_seen = 0;
        prev_req    = '0;
        prev_ready  = 1'b0;
        $readmemh("verification/cpu_stimulus.txt", stim);
        store_count = int'(stim[META_BASE + 8'd1]);
        if ((int'(stim[META_BASE]) == 0) || (store_count == 0)) begin
            report_failure("stimulus file is missing or has no program or stores");
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < int'(stim[META_BASE])) begin
                mem[8'(i)] = stim[8'(i)];
            end else begin
                mem[8'(i)] = 32'hc0de_0000 ^ 32'(i << 2); // unique per address
            end
        end
        prog_len = int'(stim[META_BASE]);

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_word("bus idle in reset", 32'd0, {30'd0, apb_req.psel, apb_req.penable});
        end
        rst = 1'b0;
        @(negedge clk);
        check_word("first setup phase", 32'd2, {30'd0, apb_req.psel, apb_req.penable});
        check_addr("reset vector fetch", RESET_VECTOR, apb_req.paddr);

        wait (stores_seen == store_count);
        // spin in the final self loop so a stray store still shows up
        repeat (CYCLES_PER_INSTR * MAX_WAIT) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
